//--- design/rs_pkg.sv
// Reservation station package: tag, instruction, FU class, ALU function, packet and slot types
`default_nettype none

package rs_pkg;

  ////////////////////////////////////////
  // Widths and bounds
  ////////////////////////////////////////

  // 64 physical registers
  typedef logic [5:0] phys_tag_t;

  // Raw instruction word
  typedef logic [31:0] inst_t;

  // Upper bound on the total slot count
  localparam int max_slots = 32;

  // Slot index wide enough for max_slots
  typedef logic [$clog2(max_slots)-1:0] slot_idx_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Functional-unit class
  typedef enum logic [2:0] {
    FU_ALU  = 3'b000,
    FU_ST   = 3'b001,
    FU_LD   = 3'b010,
    FU_MULT = 3'b011,
    FU_BR   = 3'b100
  } fu_t;

  // Operation code carried through to the FU
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,
    ALU_BIS    = 5'h04,
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_MULQ   = 5'h0b,
    ALU_CMPEQ  = 5'h0c,
    ALU_CMPLT  = 5'h0d,
    ALU_CMPLE  = 5'h0e,
    ALU_CMPULT = 5'h0f,
    ALU_CMPULE = 5'h10
  } alu_func_t;

  ////////////////////////////////////////
  // Packets
  ////////////////////////////////////////

  // Source operand tag plus its ready bit, 7 bits
  typedef struct packed {
    phys_tag_t tag;
    logic      ready;
  } src_tag_t;

  // Dispatch packet, 60 bits
  typedef struct packed {
    inst_t     inst;
    fu_t       fu;
    alu_func_t func;
    phys_tag_t dest;
    src_tag_t  t1;
    src_tag_t  t2;
  } rs_dispatch_t;

  // Issue packet, tags only, 58 bits
  typedef struct packed {
    inst_t     inst;
    fu_t       fu;
    alu_func_t func;
    phys_tag_t dest;
    phys_tag_t t1_tag;
    phys_tag_t t2_tag;
  } rs_issue_t;

  // One stored slot, 62 bits
  typedef struct packed {
    logic         busy;
    logic         issued;
    rs_dispatch_t disp;
  } rs_entry_t;

endpackage

`default_nettype wire

//--- design/rs_control.sv
// Issue handshake FSM with dispatch write enable and slot mark/free commands
`timescale 1ns/1ps
`default_nettype none

module rs_control (
  input  logic               clock,
  input  logic               rst_n,
  // Dispatch side
  input  logic               dispatch_en,
  input  logic               alloc_found,
  input  rs_pkg::slot_idx_t  alloc_slot,
  // Picker side
  input  logic               pick_valid,
  input  rs_pkg::slot_idx_t  pick_slot,
  input  rs_pkg::rs_issue_t  pick_packet,
  // Issue port
  input  logic               issue_ack,
  // Bank commands
  output logic               wr_en,
  output rs_pkg::slot_idx_t  wr_slot,
  output logic               mark_en,
  output rs_pkg::slot_idx_t  mark_slot,
  output logic               free_en,
  output rs_pkg::slot_idx_t  free_slot,
  output logic               issue_req,
  output rs_pkg::rs_issue_t  issue
);

  // IDLE waits for a ready slot, REQ holds the request, DROP waits for ack low
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    REQ  = 2'b01,
    DROP = 2'b10
  } state_t;

  state_t             state_q;
  state_t             state_d;
  rs_pkg::slot_idx_t  inflight_q;
  rs_pkg::rs_issue_t  issue_q;

  ////////////////////////////////////////
  // Dispatch write
  ////////////////////////////////////////

  // Held dispatch is dropped when class is full
  assign wr_en   = dispatch_en & alloc_found;
  assign wr_slot = alloc_slot;

  ////////////////////////////////////////
  // Bank commands
  ////////////////////////////////////////

  // Slot leaves the ready pool the edge it is latched
  assign mark_en   = (state_q == IDLE) & pick_valid;
  assign mark_slot = pick_slot;

  // Slot released on the ack edge
  assign free_en   = (state_q == REQ) & issue_ack;
  assign free_slot = inflight_q;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (pick_valid) state_d = REQ;
      REQ:  if (issue_ack) state_d = DROP;
      // Four-phase return to zero
      DROP: if (!issue_ack) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      inflight_q <= '0;
    end else begin
      state_q <= state_d;
      if (mark_en) begin
        inflight_q <= pick_slot;
      end
    end
  end

  // Packet held stable for the whole request
  always_ff @(posedge clock) begin
    if (mark_en) begin
      issue_q <= pick_packet;
    end
  end

  assign issue_req = (state_q == REQ);
  assign issue     = issue_q;

endmodule

`default_nettype wire

//--- design/rs_entry_bank.sv
// Slot storage with write/mark/free, CDB wakeup, busy and ready vectors
`timescale 1ns/1ps
`default_nettype none

module rs_entry_bank #(
  parameter int num_slots = 11
) (
  input  logic                                 clock,
  input  logic                                 rst_n,
  // Dispatch write
  input  logic                                 wr_en,
  input  rs_pkg::slot_idx_t                    wr_slot,
  input  rs_pkg::rs_dispatch_t                 dispatch,
  // Common data bus
  input  logic                                 complete_en,
  input  rs_pkg::phys_tag_t                    cdb_tag,
  // Issue bookkeeping
  input  logic                                 mark_en,
  input  rs_pkg::slot_idx_t                    mark_slot,
  input  logic                                 free_en,
  input  rs_pkg::slot_idx_t                    free_slot,
  // Status out
  output logic [num_slots-1:0]                 busy_vec,
  output logic [num_slots-1:0]                 ready_vec,
  output rs_pkg::rs_entry_t [num_slots-1:0]    entries
);

  logic [num_slots-1:0]                busy_q;
  logic [num_slots-1:0]                issued_q;
  rs_pkg::rs_dispatch_t [num_slots-1:0] disp_q;

  // Incoming packet after same-cycle wakeup
  rs_pkg::rs_dispatch_t disp_woken;

  // Per-slot CDB hits on stored sources
  logic [num_slots-1:0] hit1;
  logic [num_slots-1:0] hit2;

  ////////////////////////////////////////
  // CDB compare
  ////////////////////////////////////////

  // Broadcast in the dispatch cycle must not be lost
  always_comb begin
    disp_woken = dispatch;
    if (complete_en && (dispatch.t1.tag == cdb_tag)) begin
      disp_woken.t1.ready = 1'b1;
    end
    if (complete_en && (dispatch.t2.tag == cdb_tag)) begin
      disp_woken.t2.ready = 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      hit1[i] = complete_en & (disp_q[i].t1.tag == cdb_tag);
      hit2[i] = complete_en & (disp_q[i].t2.tag == cdb_tag);
    end
  end

  ////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////

  // Write, mark and free never target the same slot in one cycle
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_slots; i++) begin
      if (!rst_n) begin
        busy_q[i]   <= 1'b0;
        issued_q[i] <= 1'b0;
      end else if (wr_en && (wr_slot == rs_pkg::slot_idx_t'(i))) begin
        busy_q[i]   <= 1'b1;
        issued_q[i] <= 1'b0;
      end else begin
        if (mark_en && (mark_slot == rs_pkg::slot_idx_t'(i))) begin
          issued_q[i] <= 1'b1;
        end
        if (free_en && (free_slot == rs_pkg::slot_idx_t'(i))) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  // Payload and source ready bits
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_slots; i++) begin
      if (wr_en && (wr_slot == rs_pkg::slot_idx_t'(i))) begin
        disp_q[i] <= disp_woken;
      end else begin
        // Ready bits only ever set, cleared by the next write
        if (hit1[i]) begin
          disp_q[i].t1.ready <= 1'b1;
        end
        if (hit2[i]) begin
          disp_q[i].t2.ready <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      entries[i].busy   = busy_q[i];
      entries[i].issued = issued_q[i];
      entries[i].disp   = disp_q[i];
      // Waiting, not yet sent, both operands present
      ready_vec[i] = busy_q[i] & ~issued_q[i]
                   & disp_q[i].t1.ready & disp_q[i].t2.ready;
    end
  end

  assign busy_vec = busy_q;

endmodule

`default_nettype wire

//--- design/rs_slot_alloc.sv
// Per-class slot range decode, lowest free slot search and dispatch hazard
`timescale 1ns/1ps
`default_nettype none

module rs_slot_alloc #(
  parameter int num_ld   = 2,
  parameter int num_st   = 2,
  parameter int num_br   = 1,
  parameter int num_mult = 2,
  parameter int num_alu  = 4
) (
  input  logic [num_ld+num_st+num_br+num_mult+num_alu-1:0] busy_vec,
  input  rs_pkg::fu_t                                      fu,
  output logic                                             alloc_found,
  output rs_pkg::slot_idx_t                                alloc_slot,
  output logic                                             rs_hazard
);

  localparam int num_slots = num_ld + num_st + num_br + num_mult + num_alu;

  // Partition order LD, ST, BR, MULT, ALU
  localparam int base_st   = num_ld;
  localparam int base_br   = base_st + num_st;
  localparam int base_mult = base_br + num_br;
  localparam int base_alu  = base_mult + num_mult;

  int base;
  int count;

  // Class range lookup
  always_comb begin
    case (fu)
      rs_pkg::FU_LD:   begin base = 0;         count = num_ld;   end
      rs_pkg::FU_ST:   begin base = base_st;   count = num_st;   end
      rs_pkg::FU_BR:   begin base = base_br;   count = num_br;   end
      rs_pkg::FU_MULT: begin base = base_mult; count = num_mult; end
      rs_pkg::FU_ALU:  begin base = base_alu;  count = num_alu;  end
      // Unknown class gets an empty range
      default:         begin base = 0;         count = 0;        end
    endcase
  end

  // Upward search, first free slot wins
  always_comb begin
    alloc_found = 1'b0;
    alloc_slot  = '0;
    for (int i = 0; i < num_slots; i++) begin
      if (!alloc_found && !busy_vec[i] && (i >= base) && (i < base + count)) begin
        alloc_found = 1'b1;
        alloc_slot  = rs_pkg::slot_idx_t'(i);
      end
    end
  end

  // Full class blocks dispatch
  assign rs_hazard = ~alloc_found;

endmodule

`default_nettype wire

//--- design/rs_issue_pick.sv
// Lowest-index ready slot priority encoder and issue packet mux
`timescale 1ns/1ps
`default_nettype none

module rs_issue_pick #(
  parameter int num_slots = 11
) (
  input  logic [num_slots-1:0]              ready_vec,
  input  rs_pkg::rs_entry_t [num_slots-1:0] entries,
  output logic                              pick_valid,
  output rs_pkg::slot_idx_t                 pick_slot,
  output rs_pkg::rs_issue_t                 pick_packet
);

  // Entry of the winning slot
  rs_pkg::rs_entry_t sel;

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  // Lowest index first, no age ordering
  always_comb begin
    pick_valid = 1'b0;
    pick_slot  = '0;
    sel        = entries[0];
    for (int i = 0; i < num_slots; i++) begin
      if (!pick_valid && ready_vec[i]) begin
        pick_valid = 1'b1;
        pick_slot  = rs_pkg::slot_idx_t'(i);
        sel        = entries[i];
      end
    end
  end

  ////////////////////////////////////////
  // Packet build
  ////////////////////////////////////////

  // Ready bits dropped, tags kept
  always_comb begin
    pick_packet.inst   = sel.disp.inst;
    pick_packet.fu     = sel.disp.fu;
    pick_packet.func   = sel.disp.func;
    pick_packet.dest   = sel.disp.dest;
    pick_packet.t1_tag = sel.disp.t1.tag;
    pick_packet.t2_tag = sel.disp.t2.tag;
  end

endmodule

`default_nettype wire

//--- design/rs_top.sv
// Reservation station top: control FSM, entry bank, slot allocator and issue picker
`timescale 1ns/1ps
`default_nettype none

module rs_top #(
  parameter int num_ld   = 2,
  parameter int num_st   = 2,
  parameter int num_br   = 1,
  parameter int num_mult = 2,
  parameter int num_alu  = 4
) (
  input  logic                 clock,
  input  logic                 rst_n,
  // Dispatch
  input  logic                 dispatch_en,
  input  rs_pkg::rs_dispatch_t dispatch,
  output logic                 rs_hazard,
  // Common data bus
  input  logic                 complete_en,
  input  rs_pkg::phys_tag_t    cdb_tag,
  // Issue, four-phase
  output logic                 issue_req,
  output rs_pkg::rs_issue_t    issue,
  input  logic                 issue_ack
);

  localparam int num_slots = num_ld + num_st + num_br + num_mult + num_alu;

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  logic [num_slots-1:0]              busy_vec;
  logic [num_slots-1:0]              ready_vec;
  rs_pkg::rs_entry_t [num_slots-1:0] entries;

  logic              alloc_found;
  rs_pkg::slot_idx_t alloc_slot;
  logic              pick_valid;
  rs_pkg::slot_idx_t pick_slot;
  rs_pkg::rs_issue_t pick_packet;

  // Bank commands
  logic              wr_en;
  rs_pkg::slot_idx_t wr_slot;
  logic              mark_en;
  rs_pkg::slot_idx_t mark_slot;
  logic              free_en;
  rs_pkg::slot_idx_t free_slot;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  rs_control u_control (
    .clock(clock), .rst_n(rst_n),
    .dispatch_en(dispatch_en), .alloc_found(alloc_found), .alloc_slot(alloc_slot),
    .pick_valid(pick_valid), .pick_slot(pick_slot), .pick_packet(pick_packet),
    .issue_ack(issue_ack),
    .wr_en(wr_en), .wr_slot(wr_slot),
    .mark_en(mark_en), .mark_slot(mark_slot),
    .free_en(free_en), .free_slot(free_slot),
    .issue_req(issue_req), .issue(issue)
  );

  rs_entry_bank #(.num_slots(num_slots)) u_bank (
    .clock(clock), .rst_n(rst_n),
    .wr_en(wr_en), .wr_slot(wr_slot), .dispatch(dispatch),
    .complete_en(complete_en), .cdb_tag(cdb_tag),
    .mark_en(mark_en), .mark_slot(mark_slot),
    .free_en(free_en), .free_slot(free_slot),
    .busy_vec(busy_vec), .ready_vec(ready_vec), .entries(entries)
  );

  // Class ranges come from the same counts as the bank size
  rs_slot_alloc #(
    .num_ld(num_ld), .num_st(num_st), .num_br(num_br),
    .num_mult(num_mult), .num_alu(num_alu)
  ) u_alloc (
    .busy_vec(busy_vec), .fu(dispatch.fu),
    .alloc_found(alloc_found), .alloc_slot(alloc_slot), .rs_hazard(rs_hazard)
  );

  rs_issue_pick #(.num_slots(num_slots)) u_pick (
    .ready_vec(ready_vec), .entries(entries),
    .pick_valid(pick_valid), .pick_slot(pick_slot), .pick_packet(pick_packet)
  );

endmodule

`default_nettype wire

//--- sim/tb_rs_tests.svh
// Compare tasks, LCG, stimulus helpers and the directed tests of the RS testbench
`ifndef TB_RS_TESTS_SVH
`define TB_RS_TESTS_SVH

  ////////////////////////////////////////
  // Compare tasks and reference models
  ////////////////////////////////////////

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED t=%0t %s: got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_issue(input rs_pkg::rs_issue_t actual, input rs_pkg::rs_issue_t expected,
                             input string what);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_tag(input rs_pkg::phys_tag_t actual, input rs_pkg::phys_tag_t expected,
                           input string what);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED t=%0t %s: got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // Full-period 32-bit LCG constants
  // Upper half has the better bits
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic rs_pkg::rs_dispatch_t build_disp(
    input rs_pkg::inst_t inst, input rs_pkg::fu_t fu, input rs_pkg::alu_func_t func,
    input rs_pkg::phys_tag_t dest, input rs_pkg::phys_tag_t tag1, input logic rdy1,
    input rs_pkg::phys_tag_t tag2, input logic rdy2);
    rs_pkg::rs_dispatch_t d;
    d.inst     = inst;
    d.fu       = fu;
    d.func     = func;
    d.dest     = dest;
    d.t1.tag   = tag1;
    d.t1.ready = rdy1;
    d.t2.tag   = tag2;
    d.t2.ready = rdy2;
    return d;
  endfunction

  // Issued packet carries the dispatched fields and drops the ready bits
  function automatic rs_pkg::rs_issue_t expected_issue(input rs_pkg::rs_dispatch_t d);
    rs_pkg::rs_issue_t p;
    p.inst   = d.inst;
    p.fu     = d.fu;
    p.func   = d.func;
    p.dest   = d.dest;
    p.t1_tag = d.t1.tag;
    p.t2_tag = d.t2.tag;
    return p;
  endfunction

  // Default slot counts of the top level
  function automatic int class_slots(input rs_pkg::fu_t fu);
    case (fu)
      rs_pkg::FU_LD:   return 2;
      rs_pkg::FU_ST:   return 2;
      rs_pkg::FU_BR:   return 1;
      rs_pkg::FU_MULT: return 2;
      rs_pkg::FU_ALU:  return 4;
      default:         return 0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus and wait helpers
  ////////////////////////////////////////

  // Accepted on the rising edge inside this call if no hazard
  task automatic drive_dispatch(input rs_pkg::rs_dispatch_t d, output logic accepted);
    dispatch    = d;
    dispatch_en = 1'b1;
    #1;
    accepted = !rs_hazard;
    @(negedge clock);
    dispatch_en = 1'b0;
  endtask

  task automatic send_cdb(input rs_pkg::phys_tag_t tag);
    complete_en = 1'b1;
    cdb_tag     = tag;
    @(negedge clock);
    complete_en = 1'b0;
  endtask

  // Packet presented without enable to look at the hazard only
  task automatic probe_hazard(input rs_pkg::rs_dispatch_t d, input logic expected,
                              input string what);
    dispatch    = d;
    dispatch_en = 1'b0;
    #1;
    check_bit(rs_hazard, expected, what);
    @(negedge clock);
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clock);
      check_bit(issue_req, 1'b0, what);
    end
  endtask

  // Three quiet edges in a row, so a pending issue would have shown up
  task automatic settle_handshake(input int max_cycles, input string what);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while ((quiet < 3) && (cycles < max_cycles)) begin
      @(negedge clock);
      cycles++;
      quiet = (!issue_req && !issue_ack) ? quiet + 1 : 0;
    end
    if (quiet < 3) begin
      err_count++;
      $display("Issue handshake still busy after %0d cycles in %s", max_cycles, what);
    end
  endtask

  task automatic await_issue_count(input int target, input int max_cycles, input string what);
    int cycles;
    cycles = 0;
    while ((issued_q.size() < target) && (cycles < max_cycles)) begin
      @(negedge clock);
      cycles++;
    end
    if (issued_q.size() < target) begin
      err_count++;
      $display("Only %0d of %0d packets issued within %0d cycles in %s",
               issued_q.size(), target, max_cycles, what);
    end
  endtask

  task automatic await_req(input logic level, input int max_cycles, input string what);
    int cycles;
    cycles = 0;
    while ((issue_req !== level) && (cycles < max_cycles)) begin
      @(negedge clock);
      cycles++;
    end
    if (issue_req !== level) begin
      err_count++;
      $display("issue_req never went to %b within %0d cycles in %s", level, max_cycles, what);
    end
  endtask

  // Request expected one edge after the last missing tag
  task automatic issue_after_wakeup(input rs_pkg::phys_tag_t tag, input rs_pkg::rs_dispatch_t d,
                                    input string what);
    send_cdb(tag);
    check_bit(issue_req, 1'b0, {what, ": no request at the wakeup edge"});
    @(negedge clock);
    check_bit(issue_req, 1'b1, {what, ": request one edge after wakeup"});
    check_issue(issue, expected_issue(d), {what, ": issued packet"});
    settle_handshake(20, what);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("Test %-22s ok", name);
    end else begin
      test_fail_count++;
      $display("Test %-22s %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic idle_after_reset();
    int errs0;
    errs0 = err_count;
    check_bit(issue_req, 1'b0, "issue_req low after reset");
    check_bit(rs_hazard, 1'b0, "rs_hazard low after reset");
    expect_quiet(20, "no issue from an empty RS");
    check_bit(issued_q.size() == 0, 1'b1, "no packet issued from an empty RS");
    report_test("idle_after_reset", errs0);
  endtask

  task automatic ready_dispatch_issue();
    rs_pkg::rs_dispatch_t d[2];
    logic acc;
    int   errs0;
    int   base;
    errs0 = err_count;
    d[0] = build_disp(32'h0040_1234, rs_pkg::FU_ALU, rs_pkg::ALU_ADDQ, 6'd5,
                      6'd1, 1'b1, 6'd2, 1'b1);
    d[1] = build_disp(32'hA5A5_0F0F, rs_pkg::FU_LD, rs_pkg::ALU_ADDQ, 6'd6,
                      6'd3, 1'b1, 6'd4, 1'b1);
    for (int k = 0; k < 2; k++) begin
      base = issued_q.size();
      drive_dispatch(d[k], acc);
      check_bit(acc, 1'b1, "ready dispatch accepted");
      check_bit(issue_req, 1'b0, "no request one edge after acceptance");
      @(negedge clock);
      check_bit(issue_req, 1'b1, "request two edges after acceptance");
      check_issue(issue, expected_issue(d[k]), "packet equals dispatched fields");
      settle_handshake(20, "ready_dispatch_issue");
      check_bit(issued_q.size() == base + 1, 1'b1, "exactly one packet per dispatch");
    end
    report_test("ready_dispatch_issue", errs0);
  endtask

  task automatic cdb_wakeup_issue();
    rs_pkg::rs_dispatch_t d;
    logic acc;
    int   errs0;
    errs0 = err_count;
    // Both sources outstanding and woken by two broadcasts
    d = build_disp(32'h1111_0001, rs_pkg::FU_ALU, rs_pkg::ALU_SUBQ, 6'd12,
                   6'd10, 1'b0, 6'd11, 1'b0);
    drive_dispatch(d, acc);
    check_bit(acc, 1'b1, "waiting dispatch accepted");
    expect_quiet(5, "no issue with both sources waiting");
    send_cdb(6'd10);
    expect_quiet(4, "no issue with one source waiting");
    issue_after_wakeup(6'd11, d, "two-tag wakeup");
    // First source woken in the dispatch cycle itself
    d = build_disp(32'h2222_0002, rs_pkg::FU_BR, rs_pkg::ALU_CMPEQ, 6'd22,
                   6'd20, 1'b0, 6'd21, 1'b0);
    complete_en = 1'b1;
    cdb_tag     = 6'd20;
    drive_dispatch(d, acc);
    complete_en = 1'b0;
    check_bit(acc, 1'b1, "dispatch with same-cycle broadcast accepted");
    expect_quiet(4, "no issue while the second source waits");
    issue_after_wakeup(6'd21, d, "same-cycle wakeup");
    report_test("cdb_wakeup_issue", errs0);
  endtask

  task automatic mult_class_hazard();
    rs_pkg::rs_dispatch_t m1;
    rs_pkg::rs_dispatch_t m2;
    rs_pkg::rs_dispatch_t m3;
    rs_pkg::rs_dispatch_t a1;
    logic acc;
    int   errs0;
    errs0 = err_count;
    m1 = build_disp(32'h3000_0001, rs_pkg::FU_MULT, rs_pkg::ALU_MULQ, 6'd30,
                    6'd40, 1'b0, 6'd40, 1'b0);
    m2 = build_disp(32'h3000_0002, rs_pkg::FU_MULT, rs_pkg::ALU_MULQ, 6'd31,
                    6'd41, 1'b0, 6'd41, 1'b0);
    m3 = build_disp(32'h3000_0003, rs_pkg::FU_MULT, rs_pkg::ALU_MULQ, 6'd32, 6'd1, 1'b1,
                    6'd2, 1'b1);
    a1 = build_disp(32'h3000_0004, rs_pkg::FU_ALU, rs_pkg::ALU_AND, 6'd33, 6'd1, 1'b1,
                    6'd2, 1'b1);
    drive_dispatch(m1, acc);
    check_bit(acc, 1'b1, "first MULT accepted");
    drive_dispatch(m2, acc);
    check_bit(acc, 1'b1, "second MULT accepted");
    probe_hazard(m3, 1'b1, "MULT hazard with both MULT slots busy");
    probe_hazard(a1, 1'b0, "no ALU hazard while MULT is full");
    issue_after_wakeup(6'd40, m1, "first MULT");
    probe_hazard(m3, 1'b0, "MULT hazard falls after ack");
    // Drain the second MULT
    issue_after_wakeup(6'd41, m2, "second MULT");
    report_test("mult_class_hazard", errs0);
  endtask

  task automatic delayed_ack_order();
    rs_pkg::rs_dispatch_t d[3];
    logic acc;
    int   errs0;
    int   base;
    int   held;
    errs0     = err_count;
    base      = issued_q.size();
    ack_delay = 4;
    for (int k = 0; k < 3; k++) begin
      d[k] = build_disp(32'h4000_0000 + k, rs_pkg::FU_ALU, rs_pkg::ALU_XOR, 6'(50 + k),
                        6'(1 + k), 1'b1, 6'(4 + k), 1'b1);
    end
    // Back to back into the lowest free ALU slots
    for (int k = 0; k < 3; k++) begin
      drive_dispatch(d[k], acc);
      check_bit(acc, 1'b1, "ALU dispatch accepted under back-pressure");
    end
    for (int k = 0; k < 3; k++) begin
      await_req(1'b1, 20, "delayed_ack_order");
      check_issue(issue, expected_issue(d[k]), "issue order follows slot order");
      check_tag(issue.dest, d[k].dest, "destination of the issued slot");
      // Request and packet hold until the FU has acked
      held = 0;
      while (issue_req && (held < ack_delay + 4)) begin
        @(negedge clock);
        held++;
        if (issue_req) begin
          check_issue(issue, expected_issue(d[k]), "packet stable while requesting");
        end
      end
      check_bit(issue_req, 1'b0, "issue_req released after ack");
      check_bit(issued_q.size() == base + k + 1, 1'b1, "issue_req held until ack");
    end
    ack_delay = 0;
    settle_handshake(20, "delayed_ack_order");
    report_test("delayed_ack_order", errs0);
  endtask

  task automatic random_vs_model();
    rs_pkg::rs_dispatch_t model_q[$];
    rs_pkg::rs_dispatch_t d;
    rs_pkg::fu_t          f;
    rs_pkg::phys_tag_t    order[8];
    rs_pkg::phys_tag_t    tmp;
    int   occ[5];
    int   ready_cnt;
    int   base;
    int   hits;
    int   idx;
    int   j;
    int   errs0;
    logic acc;
    errs0     = err_count;
    base      = issued_q.size();
    ready_cnt = 0;
    foreach (occ[i]) occ[i] = 0;
    // Slots stay busy during dispatch, so occupancy predicts the hazard
    ack_hold = 1'b1;
    for (int k = 0; k < 10; k++) begin
      f = rs_pkg::fu_t'(lcg_next() % 5);
      d = build_disp({lcg_next(), lcg_next()}, f, rs_pkg::alu_func_t'(lcg_next() % 17),
                     6'(k), 6'(32 + lcg_next() % 8), lcg_next() % 4 == 0,
                     6'(32 + lcg_next() % 8), lcg_next() % 2 == 0);
      drive_dispatch(d, acc);
      check_bit(acc, occ[int'(f)] < class_slots(f), "random dispatch hazard by occupancy");
      if (acc) begin
        occ[int'(f)]++;
        model_q.push_back(d);
        ready_cnt += (d.t1.ready && d.t2.ready) ? 1 : 0;
      end
    end
    ack_hold = 1'b0;
    // Only entries with both tags ready may go before any broadcast
    await_issue_count(base + ready_cnt, 100, "random_vs_model ready phase");
    settle_handshake(20, "random_vs_model ready phase");
    expect_quiet(6, "no issue while tags are outstanding");
    check_bit(issued_q.size() == base + ready_cnt, 1'b1, "issue count before wakeup");
    for (int i = 0; i < 8; i++) begin
      order[i] = 6'(32 + i);
    end
    for (int i = 7; i > 0; i--) begin
      j        = lcg_next() % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
      send_cdb(order[i]);
    end
    await_issue_count(base + model_q.size(), 200, "random_vs_model wakeup phase");
    settle_handshake(20, "random_vs_model wakeup phase");
    check_bit(issued_q.size() == base + model_q.size(), 1'b1, "issue count matches model");
    // Destination tags are unique, so they identify each instruction
    foreach (model_q[m]) begin
      hits = 0;
      idx  = base;
      for (int q = base; q < issued_q.size(); q++) begin
        if (issued_q[q].dest == model_q[m].dest) begin
          hits++;
          idx = q;
        end
      end
      check_bit(hits == 1, 1'b1, "model instruction issued exactly once");
      check_issue(issued_q[idx], expected_issue(model_q[m]), "issued packet matches model");
    end
    report_test("random_vs_model", errs0);
  endtask

`endif

//--- sim/tb_rs_top.sv
// Testbench top: clock, reset, watchdog, DUT instance, FU responder and test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_rs_top;

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 10;
  // Sum of all test lengths with margin
  localparam int watchdog_cycles = 2000;

  logic                 clock;
  logic                 rst_n;
  logic                 dispatch_en;
  rs_pkg::rs_dispatch_t dispatch;
  logic                 rs_hazard;
  logic                 complete_en;
  rs_pkg::phys_tag_t    cdb_tag;
  logic                 issue_req;
  rs_pkg::rs_issue_t    issue;
  logic                 issue_ack;

  // FU responder knobs, plus every packet the FU accepted
  int                ack_delay;
  logic              ack_hold;
  rs_pkg::rs_issue_t issued_q[$];

  // Bookkeeping
  int          err_count;
  int          test_count;
  int          test_fail_count;
  logic [31:0] lcg_state;

  rs_top dut0 (
    .clock(clock), .rst_n(rst_n),
    .dispatch_en(dispatch_en), .dispatch(dispatch), .rs_hazard(rs_hazard),
    .complete_en(complete_en), .cdb_tag(cdb_tag),
    .issue_req(issue_req), .issue(issue), .issue_ack(issue_ack)
  );

  `include "tb_rs_tests.svh"

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever begin
      #(clk_period / 2) clock = ~clock;
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // FU responder
  ////////////////////////////////////////

  // Four-phase partner on the issue port
  initial begin : fu_responder
    int wait_cnt;
    issue_ack = 1'b0;
    forever begin
      @(negedge clock);
      if (rst_n && issue_req && !issue_ack) begin
        wait_cnt = 0;
        // Back-pressure, by delay or by hold
        while (ack_hold || (wait_cnt < ack_delay)) begin
          @(negedge clock);
          wait_cnt++;
        end
        issued_q.push_back(issue);
        issue_ack = 1'b1;
        // RS drops req on the ack edge, then ack returns to zero
        do begin
          @(negedge clock);
        end while (issue_req);
        issue_ack = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    dispatch_en     = 1'b0;
    dispatch        = '0;
    complete_en     = 1'b0;
    cdb_tag         = '0;
    ack_delay       = 0;
    ack_hold        = 1'b0;
    err_count       = 0;
    test_count      = 0;
    test_fail_count = 0;
    lcg_state       = 32'd69;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);

    // All tests start and end on a falling edge
    idle_after_reset();
    ready_dispatch_issue();
    cdb_wakeup_issue();
    mult_class_hazard();
    delayed_ack_order();
    random_vs_model();

    $display("Summary: %0d tests, %0d failing, %0d errors",
             test_count, test_fail_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rs_top.f
+incdir+sim
design/rs_pkg.sv
design/rs_control.sv
design/rs_entry_bank.sv
design/rs_slot_alloc.sv
design/rs_issue_pick.sv
design/rs_top.sv
sim/tb_rs_top.sv
